//--- flist.f
source/commu_pkg.sv
source/frm_edge_detect.sv
source/pkg_buf_counter.sv
source/commu_m_main.sv
source/commu_m_top.sv
test/tb_clk_gen.sv
test/tb_commu_m.sv

//--- Makefile
TOP = tb_commu_m

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f flist.f \
		--Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: no errors" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- test/tb_commu_m.sv
// directed tests for the packet notification block
// compare tasks, cycle timeout and result message

`timescale 1ns/1ns

module tb_commu_m;

	logic clk_sys;
	logic rst_n;
	logic pkg_done;
	logic buf_frm;
	logic repk_frm;
	logic arm_int_n;
	logic wd_arm_high;
	commu_pkg::stu_t     stu_buf_rdy;
	commu_pkg::cnt_pkg_t cnt_pkg_buf;
	commu_pkg::cnt_wait_t cycle_cnt = '0;

	// a frame edge reaches the controller on the third clock edge
	localparam int EDGE_MARGIN = 4;
	localparam commu_pkg::cnt_wait_t TIMEOUT_CYCLES = commu_pkg::T_POR +
		32'd2 * commu_pkg::T_WD_ARM_HIGH + 32'd6 * commu_pkg::T_DOWN + 32'd200;

	tb_clk_gen clk_gen0 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	commu_m_top dut0 (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.pkg_done    (pkg_done),
		.buf_frm     (buf_frm),
		.repk_frm    (repk_frm),
		.arm_int_n   (arm_int_n),
		.stu_buf_rdy (stu_buf_rdy),
		.cnt_pkg_buf (cnt_pkg_buf),
		.wd_arm_high (wd_arm_high)
	);

	// --------------------------------------------------
	// failure and compare tasks
	// --------------------------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_cnt(input string test, input commu_pkg::cnt_pkg_t exp,
		input commu_pkg::cnt_pkg_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: cnt_pkg_buf expected %0d, actual %0d",
				test, exp, act));
		end
	endtask

	task automatic check_stu(input string test, input commu_pkg::stu_t exp,
		input commu_pkg::stu_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: stu_buf_rdy expected %h, actual %h",
				test, exp, act));
		end
	endtask

	task automatic check_bit(input string test, input string sig, input logic exp,
		input logic act);
		if (act !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: %s expected %b, actual %b",
				test, sig, exp, act));
		end
	endtask

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	// pkg_done high for n back-to-back cycles, one packet each
	task automatic send_packets(input int n);
		@(posedge clk_sys);
		pkg_done <= 1'b1;
		repeat (n) @(posedge clk_sys);
		pkg_done <= 1'b0;
	endtask

	task automatic wait_int_level(input string test, input logic level, input int max_cycles);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (arm_int_n !== level && n < max_cycles);
		if (arm_int_n !== level) begin
			stop_with_failure($sformatf("%s: arm_int_n did not go to %b within %0d cycles",
				test, level, max_cycles));
		end
	endtask

	// one packet read, ends with a falling repk_frm
	task automatic read_packet(input string test, input commu_pkg::cnt_pkg_t exp);
		@(posedge clk_sys);
		repk_frm <= 1'b1;
		repeat (2) @(posedge clk_sys);
		repk_frm <= 1'b0;
		// count settles on the third edge after the fall
		repeat (EDGE_MARGIN) @(negedge clk_sys);
		check_cnt(test, exp, cnt_pkg_buf);
	endtask

	task automatic ack_interrupt(input string test);
		@(posedge clk_sys);
		buf_frm <= 1'b1;
		// two sync flops, the state change and the output register
		wait_int_level(test, 1'b1, EDGE_MARGIN + 2);
		check_stu(test, commu_pkg::STU_IDLE, stu_buf_rdy);
		@(posedge clk_sys);
		buf_frm <= 1'b0;
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic reset_and_guard();
		@(negedge clk_sys);
		check_bit("reset_guard", "arm_int_n", 1'b1, arm_int_n);
		check_stu("reset_guard", commu_pkg::STU_IDLE, stu_buf_rdy);
		check_bit("reset_guard", "wd_arm_high", 1'b0, wd_arm_high);
		check_cnt("reset_guard", 4'd0, cnt_pkg_buf);
		send_packets(2);
		@(negedge clk_sys);
		check_cnt("reset_guard", 4'd2, cnt_pkg_buf);
		// guard ends 16 edges after release, 3 used by the packets
		repeat (commu_pkg::T_POR - 32'd2) begin
			@(negedge clk_sys);
			check_bit("reset_guard", "arm_int_n", 1'b1, arm_int_n);
		end
		wait_int_level("reset_guard", 1'b0, 3);
		check_stu("reset_guard", commu_pkg::STU_READY, stu_buf_rdy);
		check_cnt("reset_guard", 4'd2, cnt_pkg_buf);
	endtask

	task automatic irq_threshold();
		read_packet("threshold", 4'd1);
		read_packet("threshold", 4'd0);
		ack_interrupt("threshold");
		send_packets(1);
		repeat (20) begin
			@(negedge clk_sys);
			check_bit("threshold", "arm_int_n", 1'b1, arm_int_n);
			check_cnt("threshold", 4'd1, cnt_pkg_buf);
		end
		send_packets(1);
		wait_int_level("threshold", 1'b0, EDGE_MARGIN);
		check_stu("threshold", commu_pkg::STU_READY, stu_buf_rdy);
	endtask

	task automatic ack_and_holdoff();
		ack_interrupt("ack_holdoff");
		repeat (commu_pkg::T_DOWN) begin
			@(negedge clk_sys);
			check_bit("ack_holdoff", "arm_int_n", 1'b1, arm_int_n);
			check_cnt("ack_holdoff", 4'd2, cnt_pkg_buf);
		end
		wait_int_level("ack_holdoff", 1'b0, EDGE_MARGIN);
		check_stu("ack_holdoff", commu_pkg::STU_READY, stu_buf_rdy);
	endtask

	task automatic count_rules();
		read_packet("count_rules", 4'd1);
		read_packet("count_rules", 4'd0);
		// floor at zero
		read_packet("count_rules", 4'd0);
		ack_interrupt("count_rules");
		send_packets(17);
		@(negedge clk_sys);
		check_cnt("count_rules", 4'd15, cnt_pkg_buf);
		read_packet("count_rules", 4'd14);
		// line pkg_done up with the internal fall pulse
		@(posedge clk_sys);
		repk_frm <= 1'b1;
		repeat (2) @(posedge clk_sys);
		repk_frm <= 1'b0;
		repeat (2) @(posedge clk_sys);
		pkg_done <= 1'b1;
		@(posedge clk_sys);
		pkg_done <= 1'b0;
		repeat (2) begin
			@(negedge clk_sys);
			check_cnt("count_rules", 4'd14, cnt_pkg_buf);
		end
	endtask

	task automatic watchdog_flush();
		ack_interrupt("watchdog");
		wait_int_level("watchdog", 1'b0, int'(commu_pkg::T_DOWN) + EDGE_MARGIN + 2);
		repeat (commu_pkg::T_WD_ARM_HIGH - 32'd1) begin
			@(negedge clk_sys);
			check_bit("watchdog", "wd_arm_high", 1'b0, wd_arm_high);
		end
		@(negedge clk_sys);
		check_bit("watchdog", "wd_arm_high", 1'b1, wd_arm_high);
		@(negedge clk_sys);
		check_bit("watchdog", "wd_arm_high", 1'b0, wd_arm_high);
		check_cnt("watchdog", 4'd0, cnt_pkg_buf);
		@(negedge clk_sys);
		check_bit("watchdog", "arm_int_n", 1'b1, arm_int_n);
		check_stu("watchdog", commu_pkg::STU_IDLE, stu_buf_rdy);
		send_packets(2);
		// still in hold-off
		repeat (commu_pkg::T_DOWN - 32'd2) begin
			@(negedge clk_sys);
			check_bit("watchdog", "arm_int_n", 1'b1, arm_int_n);
		end
		wait_int_level("watchdog", 1'b0, EDGE_MARGIN);
		check_cnt("watchdog", 4'd2, cnt_pkg_buf);
	endtask

	// --------------------------------------------------
	// run limit and test sequence
	// --------------------------------------------------
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 32'd1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout: tests did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	initial begin
		pkg_done = 1'b0;
		buf_frm  = 1'b0;
		repk_frm = 1'b0;
		wait (rst_n === 1'b1);
		reset_and_guard();
		irq_threshold();
		ack_and_holdoff();
		count_rules();
		watchdog_flush();
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- test/tb_clk_gen.sv
// testbench clock, 100 ns period, and reset held low for 4 cycles

`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

//--- source/commu_m_top.sv
// top level: frame synchronizers, packet counter and controller

`timescale 1ns/1ns

module commu_m_top (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                pkg_done,
	input  logic                buf_frm,
	input  logic                repk_frm,
	output logic                arm_int_n,
	output commu_pkg::stu_t     stu_buf_rdy,
	output commu_pkg::cnt_pkg_t cnt_pkg_buf,
	output logic                wd_arm_high
);

	logic buf_frm_rise;
	logic repk_frm_fall;

	// --------------------------------------------------
	// ARM frame signals into clk_sys
	// --------------------------------------------------
	frm_edge_detect u_buf_frm_edge (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.frm     (buf_frm),
		.rise    (buf_frm_rise),
		.fall    ()
	);

	// end of each packet read
	frm_edge_detect u_repk_frm_edge (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.frm     (repk_frm),
		.rise    (),
		.fall    (repk_frm_fall)
	);

	// --------------------------------------------------
	// packet count and controller
	// --------------------------------------------------
	pkg_buf_counter u_pkg_buf_counter (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.pkg_done      (pkg_done),
		.repk_frm_fall (repk_frm_fall),
		.flush         (wd_arm_high),
		.cnt_pkg_buf   (cnt_pkg_buf)
	);

	commu_m_main u_commu_m_main (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.cnt_pkg_buf  (cnt_pkg_buf),
		.buf_frm_rise (buf_frm_rise),
		.arm_int_n    (arm_int_n),
		.stu_buf_rdy  (stu_buf_rdy),
		.wd_arm_high  (wd_arm_high)
	);

endmodule

//--- source/commu_m_main.sv
// interrupt FSM with power-on guard, ARM watchdog and hold-off
// drives the interrupt line and the buffer-ready status word

`timescale 1ns/1ns

module commu_m_main (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  commu_pkg::cnt_pkg_t cnt_pkg_buf,
	input  logic                buf_frm_rise,
	output logic                arm_int_n,
	output commu_pkg::stu_t     stu_buf_rdy,
	output logic                wd_arm_high
);

	commu_pkg::st_buf_t st_buf;

	commu_pkg::cnt_wait_t cnt_por;
	commu_pkg::cnt_wait_t cnt_wd;
	commu_pkg::cnt_wait_t cnt_down;

	logic finish_rst;
	logic finish_down;
	logic bufpkg_now;

	// --------------------------------------------------
	// power-on guard
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_por <= '0;
		end else if (!finish_rst) begin
			cnt_por <= cnt_por + 32'd1;
		end
	end

	// stops counting here
	assign finish_rst = (cnt_por == commu_pkg::T_POR);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	assign bufpkg_now = (cnt_pkg_buf > commu_pkg::CNT_PKG_IRQ);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_buf <= commu_pkg::RST;
		end else begin
			case (st_buf)
				commu_pkg::RST: begin
					if (finish_rst) begin
						st_buf <= commu_pkg::IDLE;
					end
				end
				commu_pkg::IDLE: begin
					if (bufpkg_now) begin
						st_buf <= commu_pkg::UP;
					end
				end
				commu_pkg::UP: begin
					// acknowledge or give up on the ARM
					if (buf_frm_rise || wd_arm_high) begin
						st_buf <= commu_pkg::DOWN;
					end
				end
				commu_pkg::DOWN: begin
					if (finish_down) begin
						st_buf <= commu_pkg::DONE;
					end
				end
				commu_pkg::DONE: begin
					st_buf <= commu_pkg::IDLE;
				end
				default: begin
					st_buf <= commu_pkg::IDLE;
				end
			endcase
		end
	end

	// hold-off in DOWN
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_down <= '0;
		end else if (st_buf == commu_pkg::DOWN) begin
			cnt_down <= cnt_down + 32'd1;
		end else begin
			cnt_down <= '0;
		end
	end

	// DOWN lasts T_DOWN cycles
	assign finish_down = (cnt_down == commu_pkg::T_DOWN - 32'd1);

	// --------------------------------------------------
	// interrupt line and watchdog
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			arm_int_n <= 1'b1;
		end else begin
			arm_int_n <= (st_buf != commu_pkg::UP);
		end
	end

	// counts cycles of interrupt held low
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_wd <= '0;
		end else if (!arm_int_n) begin
			cnt_wd <= cnt_wd + 32'd1;
		end else begin
			cnt_wd <= '0;
		end
	end

	// only fires while still waiting in UP, so a late ack cannot flush
	assign wd_arm_high = (st_buf == commu_pkg::UP) &&
		(cnt_wd == commu_pkg::T_WD_ARM_HIGH);

	// status word follows the line
	assign stu_buf_rdy = arm_int_n ? commu_pkg::STU_IDLE : commu_pkg::STU_READY;

endmodule

//--- source/pkg_buf_counter.sv
// count of packets waiting for the ARM
// saturates at both ends, cleared by the watchdog flush

`timescale 1ns/1ns

module pkg_buf_counter (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               pkg_done,
	input  logic               repk_frm_fall,
	input  logic               flush,
	output commu_pkg::cnt_pkg_t cnt_pkg_buf
);

	localparam commu_pkg::cnt_pkg_t CNT_MAX  = 4'd15;
	localparam commu_pkg::cnt_pkg_t CNT_ZERO = 4'd0;

	logic cnt_full;
	logic cnt_empty;

	assign cnt_full  = (cnt_pkg_buf == CNT_MAX);
	assign cnt_empty = (cnt_pkg_buf == CNT_ZERO);

	// --------------------------------------------------
	// count update
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_pkg_buf <= CNT_ZERO;
		end else if (flush) begin
			// ARM missed these, drop them all
			cnt_pkg_buf <= CNT_ZERO;
		end else begin
			case ({pkg_done, repk_frm_fall})
				2'b10: begin
					if (!cnt_full) begin
						cnt_pkg_buf <= cnt_pkg_buf + 4'd1;
					end
				end
				2'b01: begin
					if (!cnt_empty) begin
						cnt_pkg_buf <= cnt_pkg_buf - 4'd1;
					end
				end
				// both or neither, hold
				default: begin
					cnt_pkg_buf <= cnt_pkg_buf;
				end
			endcase
		end
	end

endmodule

//--- source/frm_edge_detect.sv
// synchronizer and edge pulses for one ARM frame level

`timescale 1ns/1ns

module frm_edge_detect (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic frm,
	output logic rise,
	output logic fall
);

	// two sync stages then one history stage
	logic frm_sync1;
	logic frm_sync2;
	logic frm_hist;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frm_sync1 <= 1'b0;
			frm_sync2 <= 1'b0;
			frm_hist  <= 1'b0;
		end else begin
			frm_sync1 <= frm;
			frm_sync2 <= frm_sync1;
			frm_hist  <= frm_sync2;
		end
	end

	// high for the cycle between the second and third flop update
	assign rise = frm_sync2 & ~frm_hist;
	assign fall = ~frm_sync2 & frm_hist;

endmodule

//--- source/commu_pkg.sv
// shared widths, controller state encoding and timing constants
// for the link-to-ARM packet notification block

package commu_pkg;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------
	typedef logic [3:0]  cnt_pkg_t;
	typedef logic [31:0] cnt_wait_t;
	typedef logic [7:0]  stu_t;

	// controller states, encoding kept from the board firmware map
	typedef enum logic [2:0] {
		IDLE = 3'h0,
		UP   = 3'h2,
		DOWN = 3'h3,
		RST  = 3'h6,
		DONE = 3'h7
	} st_buf_t;

	// --------------------------------------------------
	// timing, shortened from the seconds used on hardware
	// --------------------------------------------------
	localparam cnt_wait_t T_POR         = 32'd16;
	localparam cnt_wait_t T_WD_ARM_HIGH = 32'd64;
	localparam cnt_wait_t T_DOWN        = 32'd8;

	// interrupt only once more than this many packets wait
	localparam cnt_pkg_t CNT_PKG_IRQ = 4'd1;

	localparam stu_t STU_READY = 8'hff;
	localparam stu_t STU_IDLE  = 8'h00;

endpackage
